// File: verilog/matmul_pkg.sv
////////////////////////////////////////
// Matrix multiplier shared definitions
// Sizes, payload types and run timing
////////////////////////////////////////
`default_nettype none

package matmul_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    // Matrix dimension, which is also the lane count of a memory word
    localparam int MAT_SIZE   = 4;
    localparam int DATA_WIDTH = 8;
    localparam int ACC_WIDTH  = 16;
    localparam int ADDR_WIDTH = 10;
    localparam int CNT_WIDTH  = 8;

    ////////////////////////////////////////
    // Run timing
    ////////////////////////////////////////

    // Pipeline stages inside one multiply-accumulate cell
    localparam int MAC_CYCLES      = 1;
    // Cycles until the last product of the mesh reaches its MAC
    localparam int SYSTOLIC_CYCLES = 14;
    // Counter value on which done is registered
    localparam int DONE_COUNT      = SYSTOLIC_CYCLES + MAC_CYCLES;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;
    typedef logic [ADDR_WIDTH-1:0]        addr_t;
    typedef logic [CNT_WIDTH-1:0]         cnt_t;

    // One memory word of A (a column) or of B (a row), lane i in element i
    typedef data_t [MAT_SIZE-1:0] lanes_t;

    // One row of C
    typedef acc_t [MAT_SIZE-1:0] row_t;

    // All accumulators of the mesh, indexed [row][column]
    typedef row_t [MAT_SIZE-1:0] acc_grid_t;

endpackage

`default_nettype wire

// File: verilog/matmul_sequencer.sv
////////////////////////////////////////
// Run sequencer
// Counts the run cycles and raises done
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module matmul_sequencer (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    output matmul_pkg::cnt_t cnt,
    output logic             done
);

    // Set from the first edge that sees start high
    logic running;

    // The count stays at zero on the first edge of a run and then steps once
    // per cycle. It stops at its top value so a long start level cannot
    // bring it back round to DONE_COUNT
    always_ff @(posedge clk) begin
        if (reset || !start) begin
            running <= 1'b0;
            cnt     <= '0;
            done    <= 1'b0;
        end else begin
            running <= 1'b1;
            if (running && (cnt != '1)) begin
                cnt <= cnt + 1'b1;
            end
            // One cycle pulse, the count has moved on by the next edge
            done <= (cnt == matmul_pkg::DONE_COUNT);
        end
    end

endmodule

`default_nettype wire

// File: verilog/operand_feed.sv
////////////////////////////////////////
// Operand feed
// Reads A and B and skews their lanes
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module operand_feed (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  matmul_pkg::cnt_t   cnt,
    input  matmul_pkg::addr_t  addr_a,
    input  matmul_pkg::addr_t  addr_b,
    input  matmul_pkg::lanes_t a_data,
    input  matmul_pkg::lanes_t b_data,
    output matmul_pkg::addr_t  a_addr,
    output matmul_pkg::addr_t  b_addr,
    output matmul_pkg::lanes_t a_edge,
    output matmul_pkg::lanes_t b_edge
);

    logic              running;
    logic              addr_phase;
    logic              rd_valid;
    matmul_pkg::addr_t rd_offset;

    // Index 0 carries the A path and index 1 the B path
    matmul_pkg::lanes_t rd_word [2];
    matmul_pkg::lanes_t skew_q  [2][matmul_pkg::MAT_SIZE];

    ////////////////////////////////////////
    // Read addresses
    ////////////////////////////////////////

    // Follows start one edge late so the cycle before edge 0 is not taken
    // as the first read step
    always_ff @(posedge clk) begin
        if (reset || !start) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign addr_phase = running && (cnt < matmul_pkg::MAT_SIZE);
    assign rd_offset  = addr_phase ? matmul_pkg::addr_t'(cnt) : '0;

    assign a_addr = addr_a + rd_offset;
    assign b_addr = addr_b + rd_offset;

    // Memory data arrives one cycle after its address
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= addr_phase;
        end
    end

    ////////////////////////////////////////
    // Lane skew
    ////////////////////////////////////////

    assign rd_word[0] = a_data;
    assign rd_word[1] = b_data;

    // Stage 0 holds the masked read word and each later stage is one cycle
    // older. Lane i is taken from stage i, which gives the diagonal wavefront
    always_ff @(posedge clk) begin
        for (int m = 0; m < 2; m++) begin
            skew_q[m][0] <= rd_valid ? rd_word[m] : '0;
            for (int d = 1; d < matmul_pkg::MAT_SIZE; d++) begin
                skew_q[m][d] <= skew_q[m][d-1];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < matmul_pkg::MAT_SIZE; i++) begin
            a_edge[i] = skew_q[0][i][i];
            b_edge[i] = skew_q[1][i][i];
        end
    end

endmodule

`default_nettype wire

// File: verilog/processing_element.sv
////////////////////////////////////////
// Processing element
// Signed MAC with operand pass-through
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module processing_element (
    input  logic              clk,
    input  logic              clear,
    input  matmul_pkg::data_t in_a,
    input  matmul_pkg::data_t in_b,
    output matmul_pkg::data_t out_a,
    output matmul_pkg::data_t out_b,
    output matmul_pkg::acc_t  acc
);

    matmul_pkg::acc_t product;

    // Both operands are signed, so they extend to the full product width
    assign product = in_a * in_b;

    always_ff @(posedge clk) begin
        if (clear) begin
            out_a <= '0;
            out_b <= '0;
            acc   <= '0;
        end else begin
            // A moves right and B moves down, one cell per cycle
            out_a <= in_a;
            out_b <= in_b;
            // Wraps at ACC_WIDTH bits on overflow
            acc   <= acc + product;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pe_array.sv
////////////////////////////////////////
// Systolic mesh
// 4x4 grid of processing elements
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module pe_array (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  matmul_pkg::lanes_t    a_edge,
    input  matmul_pkg::lanes_t    b_edge,
    output matmul_pkg::acc_grid_t acc
);

    logic pe_clear;

    // a_link[i][j] enters cell (i, j) from the left and b_link[i][j] from above
    matmul_pkg::data_t a_link [matmul_pkg::MAT_SIZE][matmul_pkg::MAT_SIZE+1];
    matmul_pkg::data_t b_link [matmul_pkg::MAT_SIZE+1][matmul_pkg::MAT_SIZE];

    // Accumulators only hold a result while a run is active
    assign pe_clear = reset || !start;

    ////////////////////////////////////////
    // Edge inputs
    ////////////////////////////////////////

    for (genvar i = 0; i < matmul_pkg::MAT_SIZE; i++) begin : g_edge
        assign a_link[i][0] = a_edge[i];
        assign b_link[0][i] = b_edge[i];
    end

    ////////////////////////////////////////
    // Mesh
    ////////////////////////////////////////

    for (genvar i = 0; i < matmul_pkg::MAT_SIZE; i++) begin : g_row
        for (genvar j = 0; j < matmul_pkg::MAT_SIZE; j++) begin : g_col
            processing_element pe_i (
                .clk   (clk),
                .clear (pe_clear),
                .in_a  (a_link[i][j]),
                .in_b  (b_link[i][j]),
                .out_a (a_link[i][j+1]),
                .out_b (b_link[i+1][j]),
                .acc   (acc[i][j])
            );
        end
    end

endmodule

`default_nettype wire

// File: verilog/result_writer.sv
////////////////////////////////////////
// Result writer
// Writes the rows of C after done
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module result_writer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  done,
    input  matmul_pkg::addr_t     addr_c,
    input  matmul_pkg::acc_grid_t acc,
    output matmul_pkg::addr_t     c_addr,
    output matmul_pkg::row_t      c_data,
    output logic                  c_valid
);

    // Snapshot of the mesh, so the run may end while rows go out
    matmul_pkg::acc_grid_t hold;

    logic                                  busy;
    logic [$clog2(matmul_pkg::MAT_SIZE)-1:0] row;

    ////////////////////////////////////////
    // Capture
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (done) begin
            hold <= acc;
        end
    end

    ////////////////////////////////////////
    // Row sequencing
    ////////////////////////////////////////

    // One row per cycle for MAT_SIZE cycles after the capture edge
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            row  <= '0;
        end else if (done) begin
            busy <= 1'b1;
            row  <= '0;
        end else if (busy) begin
            row <= row + 1'b1;
            if (row == matmul_pkg::MAT_SIZE - 1) begin
                busy <= 1'b0;
            end
        end
    end

    // Row counter wraps back to zero after the last row
    assign c_valid = busy;
    assign c_data  = hold[row];
    assign c_addr  = addr_c + matmul_pkg::addr_t'(row);

endmodule

`default_nettype wire

// File: verilog/matmul_systolic.sv
////////////////////////////////////////
// 4x4 systolic matrix multiplier top
// Connects the feed, mesh and writer
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module matmul_systolic (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  matmul_pkg::addr_t  addr_a,
    input  matmul_pkg::addr_t  addr_b,
    input  matmul_pkg::addr_t  addr_c,
    input  matmul_pkg::lanes_t a_data,
    input  matmul_pkg::lanes_t b_data,
    output matmul_pkg::addr_t  a_addr,
    output matmul_pkg::addr_t  b_addr,
    output matmul_pkg::addr_t  c_addr,
    output matmul_pkg::row_t   c_data,
    output logic               c_valid,
    output logic               done
);

    matmul_pkg::cnt_t      cnt;
    matmul_pkg::lanes_t    a_edge;
    matmul_pkg::lanes_t    b_edge;
    matmul_pkg::acc_grid_t acc;

    matmul_sequencer sequencer_i (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .cnt   (cnt),
        .done  (done)
    );

    operand_feed feed_i (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .cnt    (cnt),
        .addr_a (addr_a),
        .addr_b (addr_b),
        .a_data (a_data),
        .b_data (b_data),
        .a_addr (a_addr),
        .b_addr (b_addr),
        .a_edge (a_edge),
        .b_edge (b_edge)
    );

    pe_array array_i (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .a_edge (a_edge),
        .b_edge (b_edge),
        .acc    (acc)
    );

    result_writer writer_i (
        .clk     (clk),
        .reset   (reset),
        .done    (done),
        .addr_c  (addr_c),
        .acc     (acc),
        .c_addr  (c_addr),
        .c_data  (c_data),
        .c_valid (c_valid)
    );

endmodule

`default_nettype wire

// File: verification/matmul_tb.sv
////////////////////////////////////////
// Systolic matrix multiplier testbench
// Directed runs against a reference model
////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module matmul_tb;

    localparam int SIZE         = matmul_pkg::MAT_SIZE;
    localparam int MEM_WORDS    = 1 << matmul_pkg::ADDR_WIDTH;
    localparam int RESET_CYCLES = 16;
    // done is registered on the edge where the run count reaches 15
    localparam int DONE_CYCLE   = 16;
    // Eight runs of about 25 cycles plus reset come to some 220 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic               clk = 1'b0;
    logic               reset;
    logic               start;
    matmul_pkg::addr_t  addr_a;
    matmul_pkg::addr_t  addr_b;
    matmul_pkg::addr_t  addr_c;
    // Read data comes from the memory models below
    matmul_pkg::lanes_t a_data = '0;
    matmul_pkg::lanes_t b_data = '0;
    matmul_pkg::addr_t  a_addr;
    matmul_pkg::addr_t  b_addr;
    matmul_pkg::addr_t  c_addr;
    matmul_pkg::row_t   c_data;
    logic               c_valid;
    logic               done;

    matmul_pkg::lanes_t a_mem [MEM_WORDS];
    matmul_pkg::lanes_t b_mem [MEM_WORDS];
    // Every row written to C in write order
    matmul_pkg::addr_t  wr_addr_q [$];
    matmul_pkg::row_t   wr_row_q  [$];

    // Operands of the next run and the expected rows of up to two runs
    matmul_pkg::data_t  mat_a [SIZE][SIZE];
    matmul_pkg::data_t  mat_b [SIZE][SIZE];
    matmul_pkg::row_t   exp_c [2][SIZE];

    // What the last run showed with cycles counted from edge 0
    matmul_pkg::addr_t  a_addr_seen [SIZE];
    matmul_pkg::addr_t  b_addr_seen [SIZE];
    int                 done_cycle;
    int                 first_valid;
    int                 last_valid;
    int                 valid_count;

    logic [31:0]        lcg_state = 32'hf323_7bc7;
    int                 cycle_count = 0;

    matmul_systolic dut_i (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .addr_a  (addr_a),
        .addr_b  (addr_b),
        .addr_c  (addr_c),
        .a_data  (a_data),
        .b_data  (b_data),
        .a_addr  (a_addr),
        .b_addr  (b_addr),
        .c_addr  (c_addr),
        .c_data  (c_data),
        .c_valid (c_valid),
        .done    (done)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // Memory models and watchdog
    ////////////////////////////////////////

    // Synchronous read returns the word one cycle after its address
    always @(posedge clk) begin
        a_data <= a_mem[a_addr];
        b_data <= b_mem[b_addr];
    end

    // C write port takes the row on the rising edge
    always @(posedge clk) begin
        if (c_valid) begin
            wr_addr_q.push_back(c_addr);
            wr_row_q.push_back(c_data);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            stop_on_failure($sformatf("Timed out after %0d cycles, the tests did not finish",
                                      cycle_count));
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic stop_on_failure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_acc(input string name, input matmul_pkg::acc_t expected,
                             input matmul_pkg::acc_t actual);
        if (actual !== expected)
            stop_on_failure($sformatf("error: time %0t, %s: expected %0d, actual %0d",
                                      $time, name, expected, actual));
    endtask

    task automatic check_addr(input string name, input matmul_pkg::addr_t expected,
                              input matmul_pkg::addr_t actual);
        if (actual !== expected)
            stop_on_failure($sformatf("error: time %0t, %s: expected 'h%0h, actual 'h%0h",
                                      $time, name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            stop_on_failure($sformatf("error: time %0t, %s: expected %0b, actual %0b",
                                      $time, name, expected, actual));
    endtask

    task automatic check_write_count(input int first, input int rows);
        if (wr_addr_q.size() - first != rows)
            stop_on_failure($sformatf("%0d rows of C were written, expected %0d",
                                      wr_addr_q.size() - first, rows));
    endtask

    // Compares SIZE recorded writes from entry first on with exp_c[slot]
    task automatic check_writes(input int slot, input int first,
                                input matmul_pkg::addr_t base_c);
        for (int r = 0; r < SIZE; r++) begin
            check_addr($sformatf("c_addr of row %0d", r), matmul_pkg::addr_t'(base_c + r),
                       wr_addr_q[first + r]);
            for (int j = 0; j < SIZE; j++)
                check_acc($sformatf("c_data row %0d lane %0d", r, j), exp_c[slot][r][j],
                          wr_row_q[first + r][j]);
        end
    endtask

    ////////////////////////////////////////
    // Operands and reference model
    ////////////////////////////////////////

    function automatic matmul_pkg::data_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return matmul_pkg::data_t'(lcg_state[31:24]);
    endfunction

    task automatic random_operands();
        for (int i = 0; i < SIZE; i++)
            for (int j = 0; j < SIZE; j++) begin
                mat_a[i][j] = next_random();
                mat_b[i][j] = next_random();
            end
    endtask

    // Word k of A is column k and word k of B is row k
    task automatic load_operands(input matmul_pkg::addr_t base_a,
                                 input matmul_pkg::addr_t base_b);
        for (int k = 0; k < SIZE; k++)
            for (int i = 0; i < SIZE; i++) begin
                a_mem[matmul_pkg::addr_t'(base_a + k)][i] = mat_a[i][k];
                b_mem[matmul_pkg::addr_t'(base_b + k)][i] = mat_b[k][i];
            end
    endtask

    // C[i][j] is the sum over k of A[i][k] * B[k][j] kept to 16 bits
    task automatic compute_expected(input int slot);
        int sum;
        for (int i = 0; i < SIZE; i++)
            for (int j = 0; j < SIZE; j++) begin
                sum = 0;
                for (int k = 0; k < SIZE; k++)
                    sum += int'(mat_a[i][k]) * int'(mat_b[k][j]);
                exp_c[slot][i][j] = matmul_pkg::acc_t'(sum);
            end
    endtask

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////

    // The rising edge after this falling edge is edge 0
    task automatic start_run(input matmul_pkg::addr_t base_a, input matmul_pkg::addr_t base_b,
                             input matmul_pkg::addr_t base_c);
        @(negedge clk);
        addr_a = base_a;
        addr_b = base_b;
        addr_c = base_c;
        start  = 1'b1;
    endtask

    task automatic run_to_done(input bit drop_start);
        int cyc;
        cyc = 0;
        done_cycle = -1;
        while (done_cycle < 0) begin
            @(negedge clk);
            if (cyc < SIZE) begin
                a_addr_seen[cyc] = a_addr;
                b_addr_seen[cyc] = b_addr;
            end else begin
                // Rows of the run before may still go out in the first cycles
                check_bit("c_valid", 1'b0, c_valid);
            end
            if (done) begin
                done_cycle = cyc;
                if (drop_start)
                    start = 1'b0;
            end
            cyc++;
        end
    endtask

    // Follows the writer through its rows and two idle cycles after them
    task automatic finish_run();
        first_valid = -1;
        last_valid  = -1;
        valid_count = 0;
        for (int cyc = done_cycle + 1; cyc <= done_cycle + SIZE + 2; cyc++) begin
            @(negedge clk);
            check_bit("done", 1'b0, done);
            if (c_valid) begin
                if (first_valid < 0)
                    first_valid = cyc;
                last_valid = cyc;
                valid_count++;
            end
        end
    endtask

    task automatic run_matmul(input matmul_pkg::addr_t base_a, input matmul_pkg::addr_t base_b,
                              input matmul_pkg::addr_t base_c);
        start_run(base_a, base_b, base_c);
        run_to_done(1'b1);
        finish_run();
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        reset = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_bit("done", 1'b0, done);
            check_bit("c_valid", 1'b0, c_valid);
        end
        reset = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_bit("done", 1'b0, done);
            check_bit("c_valid", 1'b0, c_valid);
        end
    endtask

    task automatic test_identity();
        int first;
        for (int i = 0; i < SIZE; i++)
            for (int j = 0; j < SIZE; j++) begin
                mat_a[i][j] = (i == j) ? 8'sd1 : 8'sd0;
                mat_b[i][j] = matmul_pkg::data_t'(i * 37 - j * 29 + 5);
                // Each row of C is then the matching row of B
                exp_c[0][i][j] = matmul_pkg::acc_t'(mat_b[i][j]);
            end
        load_operands(10'h000, 10'h010);
        first = wr_addr_q.size();
        run_matmul(10'h000, 10'h010, 10'h040);
        check_write_count(first, SIZE);
        check_writes(0, first, 10'h040);
    endtask

    task automatic test_random_values();
        int first;
        matmul_pkg::addr_t base_a;
        matmul_pkg::addr_t base_b;
        for (int run = 0; run < 3; run++) begin
            random_operands();
            // Extreme rows and columns push C[0][0] and C[1][1] past 16 bits
            for (int k = 0; k < SIZE; k++) begin
                if (run == 0) begin
                    mat_a[0][k] = -8'sd128;
                    mat_b[k][0] = -8'sd128;
                end else if (run == 1) begin
                    mat_a[1][k] = 8'sd127;
                    mat_b[k][1] = -8'sd128;
                end
            end
            compute_expected(0);
            base_a = matmul_pkg::addr_t'(10'h100 + run * 32);
            base_b = matmul_pkg::addr_t'(10'h110 + run * 32);
            load_operands(base_a, base_b);
            first = wr_addr_q.size();
            run_matmul(base_a, base_b, 10'h060);
            check_write_count(first, SIZE);
            check_writes(0, first, 10'h060);
        end
    endtask

    task automatic test_done_timing();
        int first;
        random_operands();
        compute_expected(0);
        load_operands(10'h200, 10'h210);
        first = wr_addr_q.size();
        start_run(10'h200, 10'h210, 10'h080);
        // Start stays high so the pulse has to end by itself
        run_to_done(1'b0);
        finish_run();
        start = 1'b0;
        if (done_cycle != DONE_CYCLE)
            stop_on_failure($sformatf("done rose in cycle %0d after edge 0, expected cycle %0d",
                                      done_cycle, DONE_CYCLE));
        if (first_valid != DONE_CYCLE + 1)
            stop_on_failure($sformatf("c_valid first rose in cycle %0d, expected cycle %0d",
                                      first_valid, DONE_CYCLE + 1));
        if (valid_count != SIZE || last_valid - first_valid + 1 != SIZE)
            stop_on_failure($sformatf("c_valid was high on %0d cycles between %0d and %0d",
                                      valid_count, first_valid, last_valid));
        check_write_count(first, SIZE);
        check_writes(0, first, 10'h080);
    endtask

    task automatic test_addresses();
        int first;
        random_operands();
        compute_expected(0);
        load_operands(10'h155, 10'h2aa);
        first = wr_addr_q.size();
        run_matmul(10'h155, 10'h2aa, 10'h3f0);
        for (int k = 0; k < SIZE; k++) begin
            check_addr($sformatf("a_addr in cycle %0d", k), matmul_pkg::addr_t'(10'h155 + k),
                       a_addr_seen[k]);
            check_addr($sformatf("b_addr in cycle %0d", k), matmul_pkg::addr_t'(10'h2aa + k),
                       b_addr_seen[k]);
        end
        check_write_count(first, SIZE);
        check_writes(0, first, 10'h3f0);
    endtask

    // Start is low for a single cycle between the two runs
    task automatic test_back_to_back();
        int first;
        random_operands();
        compute_expected(0);
        load_operands(10'h300, 10'h310);
        random_operands();
        compute_expected(1);
        load_operands(10'h320, 10'h330);
        first = wr_addr_q.size();
        start_run(10'h300, 10'h310, 10'h0c0);
        run_to_done(1'b1);
        start_run(10'h320, 10'h330, 10'h0c0);
        run_to_done(1'b1);
        finish_run();
        if (done_cycle != DONE_CYCLE)
            stop_on_failure($sformatf("done of the second run rose in cycle %0d, expected %0d",
                                      done_cycle, DONE_CYCLE));
        check_write_count(first, 2 * SIZE);
        check_writes(0, first, 10'h0c0);
        check_writes(1, first + SIZE, 10'h0c0);
    endtask

    initial begin
        reset  = 1'b1;
        start  = 1'b0;
        addr_a = '0;
        addr_b = '0;
        addr_c = '0;
        for (int adr = 0; adr < MEM_WORDS; adr++) begin
            a_mem[adr] = matmul_pkg::lanes_t'(adr * 32'h0004_0803 + 32'h1357_9bdf);
            b_mem[adr] = matmul_pkg::lanes_t'(adr * 32'h0002_1005 ^ 32'h2468_ace0);
        end
        test_reset_state();
        test_identity();
        test_random_values();
        test_done_timing();
        test_addresses();
        test_back_to_back();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/matmul_pkg.sv
verilog/matmul_sequencer.sv
verilog/operand_feed.sv
verilog/processing_element.sv
verilog/pe_array.sv
verilog/result_writer.sv
verilog/matmul_systolic.sv
verification/matmul_tb.sv

// File: Makefile
# Verilator build and run of the systolic matrix multiplier testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= matmul_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

# Passes only when the simulation prints the pass message
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf $(OBJ_DIR)
